// ==== design/cpuCfgPkg.sv ====
package cpuCfgPkg;

    // ====================
    // Machine widths
    // ====================

    // Word size of the datapath
    localparam int DataWidth    = 32;

    // General register set
    localparam int RegCount     = 32;
    localparam int RegIdxBits   = $clog2(RegCount);

    // Byte offset bits below the word index
    localparam int WordByteBits = 2;

    // ====================
    // Memory geometry
    // ====================

    // Depth of both memories, in words
    localparam int MemAddrBits  = 6;
    localparam int MemWords     = 1 << MemAddrBits;

    // Width-carrying vector types
    typedef logic [DataWidth-1:0]          word_t;
    typedef logic [RegIdxBits-1:0]         regIdx_t;
    typedef logic [MemAddrBits-1:0]        memIdx_t;

    // Flat image, word 0 in the low bits
    typedef logic [DataWidth*MemWords-1:0] memImage_t;

endpackage

// ==== design/mipsIsaPkg.sv ====
package mipsIsaPkg;

    // ====================
    // Instruction fields
    // ====================

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Opcodes of the subset
    localparam opcode_t OpRType = 6'd0;
    localparam opcode_t OpBeq   = 6'd4;
    localparam opcode_t OpAddi  = 6'd8;
    localparam opcode_t OpAndi  = 6'd12;
    localparam opcode_t OpOri   = 6'd13;
    localparam opcode_t OpLw    = 6'd35;
    localparam opcode_t OpSw    = 6'd43;

    // R-type function codes
    localparam funct_t FunctAdd = 6'd32;
    localparam funct_t FunctSub = 6'd34;
    localparam funct_t FunctAnd = 6'd36;
    localparam funct_t FunctOr  = 6'd37;
    localparam funct_t FunctSlt = 6'd42;

    // ====================
    // Control encodings
    // ====================

    // Coarse ALU class from main control
    typedef enum logic [2:0] {
        aluOpAdd,
        aluOpSub,
        aluOpAnd,
        aluOpOr,
        aluOpFunct
    } aluOp_t;

    // Final ALU operation, classic MIPS codes
    typedef enum logic [3:0] {
        aluAnd  = 4'b0000,
        aluOr   = 4'b0001,
        aluAdd  = 4'b0010,
        aluSub  = 4'b0110,
        aluSlt  = 4'b0111,
        aluPass = 4'b1111
    } aluCtrl_t;

    // Per-instruction control lines
    typedef struct packed {
        logic     regDst;
        logic     branch;
        logic     memRead;
        logic     memToReg;
        logic     memWrite;
        logic     aluSrc;
        logic     regWrite;
        aluCtrl_t aluCtrl;
    } ctrlBundle_t;

    // Decode result shared by the datapath
    typedef struct packed {
        cpuCfgPkg::regIdx_t rs;
        cpuCfgPkg::regIdx_t rt;
        cpuCfgPkg::regIdx_t wrIdx;
        cpuCfgPkg::word_t   imm;
        ctrlBundle_t        ctrl;
    } decoded_t;

endpackage

// ==== design/fetchUnit.sv ====
module fetchUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  cpuCfgPkg::memImage_t instMemImage,
    input  logic                 branchTaken,
    input  cpuCfgPkg::word_t     branchOffset,
    output cpuCfgPkg::word_t     instr
);
    import cpuCfgPkg::*;

    word_t   pc;
    word_t   pcPlus4;
    word_t   branchTarget;
    word_t   pcNext;
    memIdx_t fetchIdx;

    // Sequential successor
    assign pcPlus4      = pc + word_t'(4);

    // Word offset scaled to bytes, relative to PC plus four
    assign branchTarget = pcPlus4 + (branchOffset << WordByteBits);

    // Branch decision already resolved in execute
    assign pcNext       = branchTaken ? branchTarget : pcPlus4;

    // PC register
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Word index only, upper PC bits wrap the program
    assign fetchIdx = pc[MemAddrBits+WordByteBits-1:WordByteBits];

    // Combinational instruction read
    assign instr = instMemImage[fetchIdx*DataWidth +: DataWidth];

    // Branch offsets are word scaled, so PC stays word aligned
    assert property (@(posedge clk) disable iff (reset)
        pc[WordByteBits-1:0] == '0)
    else
        $error("fetchUnit: misaligned PC %h", pc);

endmodule

// ==== design/decodeUnit.sv ====
module decodeUnit (
    input  cpuCfgPkg::word_t     instr,
    output mipsIsaPkg::decoded_t dec
);
    import cpuCfgPkg::*;
    import mipsIsaPkg::*;

    opcode_t     opcode;
    funct_t      funct;
    regIdx_t     rtIdx;
    regIdx_t     rdIdx;
    aluOp_t      aluOp;
    aluCtrl_t    aluCtrl;
    logic        functOk;
    ctrlBundle_t mainCtrl;

    // Field split
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rtIdx  = instr[20:16];
    assign rdIdx  = instr[15:11];

    // ====================
    // Main control
    // ====================
    always_comb begin
        // Unlisted opcodes fall through as no-ops
        mainCtrl = '0;
        aluOp    = aluOpAdd;
        case (opcode)
            OpRType: begin
                mainCtrl.regDst   = 1'b1;
                mainCtrl.regWrite = 1'b1;
                aluOp             = aluOpFunct;
            end
            OpAddi: begin
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.regWrite = 1'b1;
            end
            OpAndi: begin
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.regWrite = 1'b1;
                aluOp             = aluOpAnd;
            end
            OpOri: begin
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.regWrite = 1'b1;
                aluOp             = aluOpOr;
            end
            OpLw: begin
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.memRead  = 1'b1;
                mainCtrl.memToReg = 1'b1;
                mainCtrl.regWrite = 1'b1;
            end
            OpSw: begin
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.memWrite = 1'b1;
            end
            OpBeq: begin
                // Compare by subtraction
                mainCtrl.branch   = 1'b1;
                aluOp             = aluOpSub;
            end
            default: begin
                mainCtrl = '0;
            end
        endcase
    end

    // ====================
    // ALU control
    // ====================
    always_comb begin
        functOk = 1'b1;
        case (aluOp)
            aluOpAdd: aluCtrl = aluAdd;
            aluOpSub: aluCtrl = aluSub;
            aluOpAnd: aluCtrl = aluAnd;
            aluOpOr:  aluCtrl = aluOr;
            default: begin
                // R-type, funct picks the operation
                case (funct)
                    FunctAdd: aluCtrl = aluAdd;
                    FunctSub: aluCtrl = aluSub;
                    FunctAnd: aluCtrl = aluAnd;
                    FunctOr:  aluCtrl = aluOr;
                    FunctSlt: aluCtrl = aluSlt;
                    default: begin
                        aluCtrl = aluPass;
                        functOk = 1'b0;
                    end
                endcase
            end
        endcase
    end

    // Assemble the decode result
    always_comb begin
        dec.rs            = instr[25:21];
        dec.rt            = rtIdx;
        dec.wrIdx         = mainCtrl.regDst ? rdIdx : rtIdx;
        // Logic immediates get sign extension too
        dec.imm           = {{(DataWidth-16){instr[15]}}, instr[15:0]};
        dec.ctrl          = mainCtrl;
        // Bad funct leaves an R-type with no effect
        dec.ctrl.regWrite = mainCtrl.regWrite & functOk;
        dec.ctrl.aluCtrl  = aluCtrl;
    end

endmodule

// ==== design/registerFile.sv ====
module registerFile (
    input  logic               clk,
    input  logic               reset,
    input  cpuCfgPkg::regIdx_t rsIdx,
    input  cpuCfgPkg::regIdx_t rtIdx,
    input  cpuCfgPkg::regIdx_t wrIdx,
    input  logic               wrEn,
    input  cpuCfgPkg::word_t   wrData,
    output cpuCfgPkg::word_t   rsData,
    output cpuCfgPkg::word_t   rtData
);
    import cpuCfgPkg::*;

    // General registers, entry 0 never written
    word_t regs [RegCount];

    // Single write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Two combinational read ports
    // Old value seen until the edge, no bypass needed in one cycle
    assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
    assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

// ==== design/aluExecute.sv ====
module aluExecute (
    input  mipsIsaPkg::decoded_t dec,
    input  cpuCfgPkg::word_t     rsData,
    input  cpuCfgPkg::word_t     rtData,
    output cpuCfgPkg::word_t     aluResult,
    output logic                 branchTaken
);
    import cpuCfgPkg::*;
    import mipsIsaPkg::*;

    word_t opB;
    logic  zero;

    // Second operand, register or immediate
    assign opB = dec.ctrl.aluSrc ? dec.imm : rtData;

    // ALU core
    always_comb begin
        case (dec.ctrl.aluCtrl)
            aluAnd:  aluResult = rsData & opB;
            aluOr:   aluResult = rsData | opB;
            // Add and sub wrap, no overflow trap
            aluAdd:  aluResult = rsData + opB;
            aluSub:  aluResult = rsData - opB;
            aluSlt:  aluResult = ($signed(rsData) < $signed(opB)) ? word_t'(1) : '0;
            aluPass: aluResult = opB;
            default: aluResult = '0;
        endcase
    end

    // Zero flag
    assign zero = (aluResult == '0);

    // beq uses sub, so zero means equal operands
    assign branchTaken = dec.ctrl.branch & zero;

    // Decode must hand over one of the defined operations
    always_comb begin
        assert final (dec.ctrl.aluCtrl inside {aluAnd, aluOr, aluAdd, aluSub, aluSlt, aluPass})
        else
            $error("aluExecute: undefined aluCtrl %b", dec.ctrl.aluCtrl);
    end

endmodule

// ==== design/dataMemory.sv ====
module dataMemory (
    input  logic                 clk,
    input  logic                 reset,
    input  cpuCfgPkg::memImage_t dataMemInit,
    input  cpuCfgPkg::word_t     addr,
    input  cpuCfgPkg::word_t     storeData,
    input  mipsIsaPkg::decoded_t dec,
    output cpuCfgPkg::word_t     wbData,
    output cpuCfgPkg::memImage_t dataMemImage
);
    import cpuCfgPkg::*;

    word_t   mem [MemWords];
    memIdx_t wordIdx;
    word_t   loadWord;

    // Word index only, addresses wrap
    assign wordIdx = addr[MemAddrBits+WordByteBits-1:WordByteBits];

    // Reset load, then synchronous store
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MemWords; i++) begin
                mem[i] <= dataMemInit[i*DataWidth +: DataWidth];
            end
        end else if (dec.ctrl.memWrite) begin
            mem[wordIdx] <= storeData;
        end
    end

    // Combinational load
    assign loadWord = dec.ctrl.memRead ? mem[wordIdx] : '0;

    // Write-back select, memory or ALU
    assign wbData = dec.ctrl.memToReg ? loadWord : addr;

    // Whole contents out, word 0 lowest
    always_comb begin
        for (int i = 0; i < MemWords; i++) begin
            dataMemImage[i*DataWidth +: DataWidth] = mem[i];
        end
    end

    // Decode never asks for load and store together
    assert property (@(posedge clk) disable iff (reset)
        !(dec.ctrl.memRead && dec.ctrl.memWrite))
    else
        $error("dataMemory: memRead and memWrite both set");

endmodule

// ==== design/singleCycleCpu.sv ====
module singleCycleCpu (
    input  logic                 clk,
    input  logic                 reset,
    input  cpuCfgPkg::memImage_t instMemImage,
    input  cpuCfgPkg::memImage_t dataMemInit,
    output cpuCfgPkg::memImage_t dataMemImage
);
    import cpuCfgPkg::*;
    import mipsIsaPkg::*;

    // Datapath nets
    word_t    instr;
    decoded_t dec;
    word_t    rsData;
    word_t    rtData;
    word_t    aluResult;
    word_t    wbData;
    logic     branchTaken;

    // ====================
    // Input side
    // ====================
    fetchUnit i_fetchUnit (
        .clk          (clk),
        .reset        (reset),
        .instMemImage (instMemImage),
        .branchTaken  (branchTaken),
        .branchOffset (dec.imm),
        .instr        (instr)
    );

    // ====================
    // Processing
    // ====================
    decodeUnit i_decodeUnit (
        .instr (instr),
        .dec   (dec)
    );

    // Write index and enable ride in the decode result
    registerFile i_registerFile (
        .clk    (clk),
        .reset  (reset),
        .rsIdx  (dec.rs),
        .rtIdx  (dec.rt),
        .wrIdx  (dec.wrIdx),
        .wrEn   (dec.ctrl.regWrite),
        .wrData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    aluExecute i_aluExecute (
        .dec         (dec),
        .rsData      (rsData),
        .rtData      (rtData),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    // ====================
    // Output side
    // ====================
    dataMemory i_dataMemory (
        .clk          (clk),
        .reset        (reset),
        .dataMemInit  (dataMemInit),
        .addr         (aluResult),
        .storeData    (rtData),
        .dec          (dec),
        .wbData       (wbData),
        .dataMemImage (dataMemImage)
    );

endmodule

// ==== bench/cpuModel.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// ====================
// Reference model
// ====================

// Architectural state, one instruction per step
word_t modelPc;
word_t modelRegs [RegCount];
word_t modelMem [MemWords];

// Byte address to word index, bits 7 to 2
function automatic memIdx_t wordIndex(input word_t addr);
    return addr[7:2];
endfunction

// r0 is never written
task automatic writeReg(input regIdx_t idx, input word_t value);
    if (idx != 5'd0) begin
        modelRegs[idx] = value;
    end
endtask

task automatic modelReset(input memImage_t init);
    modelPc = '0;
    for (int i = 0; i < RegCount; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < MemWords; i++) begin
        modelMem[i] = init[i*32 +: 32];
    end
endtask

task automatic modelStep(input memImage_t prog, output logic stored, output memIdx_t storeIdx);
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t nextPc;
    regIdx_t rd;
    regIdx_t rt;
    ins = prog[wordIndex(modelPc)*32 +: 32];
    rt = ins[20:16];
    rd = ins[15:11];
    // Operands read before any write of this step
    a = modelRegs[ins[25:21]];
    b = modelRegs[rt];
    // Every immediate sign-extended, logic ops too
    imm = {{16{ins[15]}}, ins[15:0]};
    nextPc = modelPc + 32'd4;
    stored = 1'b0;
    storeIdx = '0;
    case (ins[31:26])
        OpRType: begin
            case (ins[5:0])
                FunctAdd: writeReg(rd, a + b);
                FunctSub: writeReg(rd, a - b);
                FunctAnd: writeReg(rd, a & b);
                FunctOr:  writeReg(rd, a | b);
                FunctSlt: writeReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                default: ;
            endcase
        end
        OpAddi: writeReg(rt, a + imm);
        OpAndi: writeReg(rt, a & imm);
        OpOri:  writeReg(rt, a | imm);
        OpLw:   writeReg(rt, modelMem[wordIndex(a + imm)]);
        OpSw: begin
            storeIdx = wordIndex(a + imm);
            modelMem[storeIdx] = b;
            stored = 1'b1;
        end
        // Target relative to the next sequential PC
        OpBeq: if (a == b) nextPc = modelPc + 32'd4 + (imm << 2);
        // Unknown opcode, plain no-op
        default: ;
    endcase
    modelPc = nextPc;
endtask

function automatic memImage_t modelImage();
    memImage_t img;
    for (int i = 0; i < MemWords; i++) begin
        img[i*32 +: 32] = modelMem[i];
    end
    return img;
endfunction

`endif

// ==== bench/cpuTb.sv ====
module cpuTb;
    import cpuCfgPkg::*;
    import mipsIsaPkg::*;

    localparam int HalfPeriod    = 10;
    localparam int ResetCycles   = 8;
    localparam int NumPrograms   = 3;
    localparam int ProgCycles    = 400;
    // All programs with their resets, plus slack
    localparam int TimeoutCycles = NumPrograms * (ProgCycles + ResetCycles) + 100;

    logic      clk;
    logic      reset;
    memImage_t instMemImage;
    memImage_t dataMemInit;
    memImage_t dataMemImage;

    memImage_t progImage;
    memImage_t initImage;
    integer    seed;
    int        cycleCount;
    logic      stored;
    memIdx_t   storeIdx;
    word_t     ins;

    `include "cpuModel.svh"

    singleCycleCpu i_singleCycleCpu (
        .clk          (clk),
        .reset        (reset),
        .instMemImage (instMemImage),
        .dataMemInit  (dataMemInit),
        .dataMemImage (dataMemImage)
    );

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // ====================
    // Checking
    // ====================
    task automatic stopRun();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkImage(input string name, input memImage_t expected,
                              input memImage_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    // Weighted opcode, registers r0..r7 to keep data flowing
    task automatic makeInstr(output word_t instr);
        int          pick;
        opcode_t     op;
        funct_t      fn;
        logic [15:0] imm;
        pick = int'($unsigned($random(seed)) % 100);
        imm  = 16'($random(seed) % 32);
        fn   = FunctAdd;
        if (pick < 30) begin
            op = OpRType;
            case ($unsigned($random(seed)) % 5)
                0: fn = FunctAdd;
                1: fn = FunctSub;
                2: fn = FunctAnd;
                3: fn = FunctOr;
                default: fn = FunctSlt;
            endcase
        end else if (pick < 45) op = OpAddi;
        else if (pick < 52) op = OpAndi;
        else if (pick < 59) op = OpOri;
        else if (pick < 71) op = OpLw;
        else if (pick < 85) op = OpSw;
        else if (pick < 95) begin
            op  = OpBeq;
            imm = 16'($random(seed) % 6);
        end else if (pick < 98) begin
            // Opcodes 16..31, none in the subset
            op = opcode_t'(16 + $unsigned($random(seed)) % 16);
        end else begin
            // R-type with funct 48..55, undefined
            op = OpRType;
            fn = funct_t'(48 + $unsigned($random(seed)) % 8);
        end
        instr = {op, regIdx_t'($unsigned($random(seed)) % 8),
                 regIdx_t'($unsigned($random(seed)) % 8), imm};
        if (op == OpRType) begin
            instr[15:0] = {regIdx_t'($unsigned($random(seed)) % 8), 5'd0, fn};
        end
    endtask

    initial begin
        seed         = 64518;
        reset        = 1'b1;
        instMemImage = '0;
        dataMemInit  = '0;
        for (int p = 0; p < NumPrograms; p++) begin
            for (int i = 0; i < MemWords; i++) begin
                makeInstr(ins);
                progImage[i*32 +: 32] = ins;
                initImage[i*32 +: 32] = $random(seed);
            end
            @(posedge clk);
            #2;
            reset        = 1'b1;
            instMemImage = progImage;
            dataMemInit  = initImage;
            repeat (ResetCycles) @(posedge clk);
            #2;
            reset = 1'b0;
            modelReset(initImage);
            // Image right after reset is the initial image
            @(negedge clk);
            checkImage("dataMemImage", initImage, dataMemImage);
            repeat (ProgCycles) begin
                @(posedge clk);
                modelStep(progImage, stored, storeIdx);
                // Outputs settled mid-cycle
                @(negedge clk);
                if (stored) begin
                    checkWord($sformatf("dataMemImage[%0d]", storeIdx), modelMem[storeIdx],
                              dataMemImage[storeIdx*32 +: 32]);
                end
                checkImage("dataMemImage", modelImage(), dataMemImage);
            end
        end
        $display("all tests passed");
        $finish;
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        stopRun();
    end

endmodule

// ==== vlog.f ====
+incdir+bench
design/cpuCfgPkg.sv
design/mipsIsaPkg.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/registerFile.sv
design/aluExecute.sv
design/dataMemory.sv
design/singleCycleCpu.sv
bench/cpuTb.sv

// ==== Makefile ====
TOP = cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module singleCycleCpu

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
